// ==== tests/alu_patterns.hex ====
// op operand_a operand_b imm expected_result expected_branch, one operation per line
// op: ADD 00 SUB 01 AND 02 OR 03 XOR 04 SLL 05 SRL 06 SRA 07 SLTS 08 SLTU 09 EQ 0a NE 0b
// LTS 0c LTU 0d GES 0e GEU 0f PL_R 10 PL_F 11 PL_G 12 PL_VADDREP 13 PL_SPCXOR 14
00 ffffffff 00000002 00000000 00000001 1
01 00000000 00000001 00000000 ffffffff 1
02 f0f0ff00 0ff0f0f0 00000000 00f0f000 1
03 12340000 00005678 00000000 12345678 1
04 aaaa5555 ffff0000 00000000 55555555 1
05 00000001 0000001f 00000000 80000000 1
06 80000000 00000004 00000000 08000000 1
07 80000000 00000004 00000000 f8000000 1
08 ffffffff 00000001 00000000 00000001 1
09 ffffffff 00000001 00000000 00000000 1
0a 12345678 12345678 00000000 00000000 1
0b 12345678 12345678 00000000 00000000 0
0c 80000000 00000001 00000000 00000000 1
0d 80000000 00000001 00000000 00000000 0
0e 80000000 00000001 00000000 00000000 0
0f 80000000 00000001 00000000 00000000 1
10 807fff01 00000000 00000000 01000100 1
10 807fff01 00000001 00000000 00000000 1
11 0280fc05 808104fd 00000000 fe7ffcfd 1
12 70909070 e020e020 ff010000 817f817f 1
12 7f810505 81ff0303 00000100 0081fe08 1
13 fffffff0 ffffffff 00000000 000003ec 1
14 12345678 01020408 00000000 12345677 1

// ==== verilog.f ====
logic/alu_pkg.sv
logic/polar_lane_split.sv
logic/polar_lane.sv
logic/alu_int_datapath.sv
logic/alu_result_stage.sv
logic/alu_top.sv
tests/alu_tb.sv

// ==== Bender.yml ====
package:
  name: alu

sources:
  - logic/alu_pkg.sv
  - logic/polar_lane_split.sv
  - logic/polar_lane.sv
  - logic/alu_int_datapath.sv
  - logic/alu_result_stage.sv
  - logic/alu_top.sv
  - target: test
    files:
      - tests/alu_tb.sv

// ==== tests/alu_tb.sv ====
// Self-checking ALU testbench driven from a pattern file
`timescale 1ns/1ps

module alu_tb;
    import alu_pkg::*;

    localparam int NUM_RECORDS      = 23;
    localparam int WORDS_PER_RECORD = 6;
    localparam int TIMEOUT_CYCLES   = 20;

    typedef struct packed {
        alu_op_e op;
        xlen_t   operand_a;
        xlen_t   operand_b;
        xlen_t   imm;
        xlen_t   exp_result;
        logic    exp_branch;
    } pattern_t;

    logic     clk_i;
    logic     rst_i;
    logic     valid_i;
    alu_req_t req_i;
    xlen_t    result_o;
    logic     branch_res_o;
    logic     valid_o;

    logic [31:0] pattern_words [WORDS_PER_RECORD*NUM_RECORDS];
    pattern_t    patterns [NUM_RECORDS];
    logic [31:0] lfsr_state;

    alu_top i_dut (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .valid_i      (valid_i),
        .req_i        (req_i),
        .result_o     (result_o),
        .branch_res_o (branch_res_o),
        .valid_o      (valid_o)
    );

    initial clk_i = 1'b0;
    always #4 clk_i = ~clk_i;

    // --------------------
    // Helpers
    // --------------------

    // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] galois_step(input logic [31:0] state);
        logic [31:0] nxt_state;
        nxt_state = state >> 1;
        if (state[0]) begin
            nxt_state = nxt_state ^ 32'h80200003;
        end
        return nxt_state;
    endfunction

    task automatic draw_bit(output logic bit_o);
        lfsr_state = galois_step(lfsr_state);
        bit_o      = lfsr_state[0];
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Error at %0t: %s expected %h, actual %h", $time, name, expected, actual);
            $display("TB FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic load_patterns();
        int base;
        $readmemh("tests/alu_patterns.hex", pattern_words);
        if ($isunknown(pattern_words[WORDS_PER_RECORD*NUM_RECORDS-1])) begin
            $display("The pattern file is missing or holds too few records");
            $display("TB FAILED");
            $fatal(1, "pattern file load");
        end
        for (int i = 0; i < NUM_RECORDS; i++) begin
            base = i * WORDS_PER_RECORD;
            patterns[i].op         = alu_op_e'(pattern_words[base][4:0]);
            patterns[i].operand_a  = pattern_words[base+1];
            patterns[i].operand_b  = pattern_words[base+2];
            patterns[i].imm        = pattern_words[base+3];
            patterns[i].exp_result = pattern_words[base+4];
            patterns[i].exp_branch = pattern_words[base+5][0];
        end
    endtask

    // Called on a falling edge
    task automatic issue_record(input pattern_t rec);
        req_i.operator  = rec.op;
        req_i.operand_a = rec.operand_a;
        req_i.operand_b = rec.operand_b;
        req_i.imm       = rec.imm;
        valid_i         = 1'b1;
    endtask

    // Counts falling edges from the issue until valid_o shows up
    task automatic wait_for_valid(output int cycles);
        @(negedge clk_i);
        valid_i = 1'b0;
        cycles  = 1;
        while (!valid_o && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk_i);
            cycles++;
        end
        if (!valid_o) begin
            $display("Timeout: valid_o did not rise within %0d cycles of the issue",
                     TIMEOUT_CYCLES);
            $display("TB FAILED");
            $fatal(1, "valid_o timeout");
        end
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        int   cycles;
        int   gap_slot;
        logic bit_hi;
        logic bit_lo;

        rst_i       = 1'b1;
        valid_i     = 1'b0;
        req_i       = '0;
        lfsr_state  = 32'h72cd3fc5;
        gap_slot    = 0;

        load_patterns();
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;

        // Outputs cleared by reset
        check_value("valid_o", 32'd0, valid_o);
        check_value("result_o", 32'd0, result_o);
        check_value("branch_res_o", 32'd0, branch_res_o);

        for (int i = 0; i < NUM_RECORDS; i++) begin
            // One idle cycle per group of three records
            if (i % 3 == 0) begin
                draw_bit(bit_hi);
                draw_bit(bit_lo);
                gap_slot = {bit_hi, bit_lo} % 3;
            end
            issue_record(patterns[i]);
            wait_for_valid(cycles);
            check_value("valid_o latency", 32'd1, cycles);
            check_value("result_o", patterns[i].exp_result, result_o);
            check_value("branch_res_o", patterns[i].exp_branch, branch_res_o);
            if (i % 3 == gap_slot) begin
                // Idle request whose sum differs from the held result
                req_i.operator  = ADD;
                req_i.operand_a = ~patterns[i].exp_result;
                req_i.operand_b = '0;
                @(negedge clk_i);
                check_value("valid_o", 32'd0, valid_o);
                check_value("result_o", patterns[i].exp_result, result_o);
                check_value("branch_res_o", patterns[i].exp_branch, branch_res_o);
            end
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== logic/alu_top.sv ====
// ALU top level with polar lane splitter, lanes, integer datapath and result stage
`timescale 1ns/1ps

module alu_top (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              valid_i,
    input  alu_pkg::alu_req_t req_i,
    output alu_pkg::xlen_t    result_o,
    output logic              branch_res_o,
    output logic              valid_o
);
    import alu_pkg::*;

    lane_in_t    lane_in [NUM_LANES];
    lane_t       lane_res [NUM_LANES];
    lane_op_e    lane_op;
    result_sel_e result_sel;
    xlen_t       int_result;
    logic        int_branch;

    polar_lane_split i_split (
        .req_i        (req_i),
        .lane_in_o    (lane_in),
        .lane_op_o    (lane_op),
        .result_sel_o (result_sel)
    );

    // Four identical SIMD lanes
    for (genvar k = 0; k < NUM_LANES; k++) begin : gen_lanes
        polar_lane i_lane (
            .lane_i    (lane_in[k]),
            .lane_op_i (lane_op),
            .lane_o    (lane_res[k])
        );
    end

    alu_int_datapath i_int (
        .req_i        (req_i),
        .int_result_o (int_result),
        .branch_res_o (int_branch)
    );

    alu_result_stage i_result (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .valid_i      (valid_i),
        .lane_i       (lane_res),
        .int_result_i (int_result),
        .branch_res_i (int_branch),
        .result_sel_i (result_sel),
        .operand_a_i  (req_i.operand_a),
        .operand_b_i  (req_i.operand_b),
        .result_o     (result_o),
        .branch_res_o (branch_res_o),
        .valid_o      (valid_o)
    );

endmodule

// ==== logic/alu_result_stage.sv ====
// Lane merge, whole-word polar operations, result select and output registers
`timescale 1ns/1ps

module alu_result_stage (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 valid_i,
    input  alu_pkg::lane_t       lane_i [alu_pkg::NUM_LANES],
    input  alu_pkg::xlen_t       int_result_i,
    input  logic                 branch_res_i,
    input  alu_pkg::result_sel_e result_sel_i,
    input  alu_pkg::xlen_t       operand_a_i,
    input  alu_pkg::xlen_t       operand_b_i,
    output alu_pkg::xlen_t       result_o,
    output logic                 branch_res_o,
    output logic                 valid_o
);
    import alu_pkg::*;

    xlen_t lanes_word;
    xlen_t vaddrep;
    xlen_t spcxor;
    xlen_t sel_result;
    xlen_t result_q;
    logic  branch_q;
    logic  valid_q;

    // --------------------
    // Polar word results
    // --------------------
    always_comb begin
        lanes_word = '0;
        vaddrep    = operand_a_i;
        spcxor     = operand_a_i;
        for (int k = 0; k < NUM_LANES; k++) begin
            // Lane 0 lands in the low byte
            lanes_word[k*LANE_W +: LANE_W] = lane_i[k];
            // Bytes of b zero-extended, sum wraps modulo 2^32
            vaddrep = vaddrep + xlen_t'(operand_b_i[k*LANE_W +: LANE_W]);
            spcxor  = spcxor ^ xlen_t'(operand_b_i[k*LANE_W +: LANE_W]);
        end
    end

    always_comb begin
        unique case (result_sel_i)
            SEL_LANES:   sel_result = lanes_word;
            SEL_VADDREP: sel_result = vaddrep;
            SEL_SPCXOR:  sel_result = spcxor;
            default:     sel_result = int_result_i;
        endcase
    end

    // --------------------
    // Output registers
    // --------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            result_q <= '0;
            branch_q <= 1'b0;
            valid_q  <= 1'b0;
        end else begin
            valid_q <= valid_i;
            // Hold the last result through idle cycles
            if (valid_i) begin
                result_q <= sel_result;
                branch_q <= branch_res_i;
            end
        end
    end

    assign result_o     = result_q;
    assign branch_res_o = branch_q;
    assign valid_o      = valid_q;

endmodule

// ==== logic/alu_int_datapath.sv ====
// Integer adder, shifter, comparator, logic operations and branch resolution
`timescale 1ns/1ps

module alu_int_datapath (
    input  alu_pkg::alu_req_t req_i,
    output alu_pkg::xlen_t    int_result_o,
    output logic              branch_res_o
);
    import alu_pkg::*;

    logic          adder_neg;
    xlen_t         adder_b;
    xlen_t         adder_sum;
    logic          adder_zero;
    logic          cmp_signed;
    logic          less;
    logic          shift_left;
    logic          shift_arith;
    xlen_t         operand_a_rev;
    xlen_t         shift_in;
    logic [XLEN:0] shift_right_ext;
    xlen_t         shift_right;
    xlen_t         shift_left_res;
    xlen_t         shift_res;

    // --------------------
    // Adder
    // --------------------
    assign adder_neg  = (req_i.operator == SUB) || (req_i.operator == EQ) ||
                        (req_i.operator == NE);
    assign adder_b    = adder_neg ? ~req_i.operand_b : req_i.operand_b;
    assign adder_sum  = req_i.operand_a + adder_b + xlen_t'(adder_neg);
    assign adder_zero = (adder_sum == '0);

    // Shared less-than, signed for SLTS, LTS and GES
    assign cmp_signed = (req_i.operator == SLTS) || (req_i.operator == LTS) ||
                        (req_i.operator == GES);
    assign less = $signed({cmp_signed & req_i.operand_a[XLEN-1], req_i.operand_a}) <
                  $signed({cmp_signed & req_i.operand_b[XLEN-1], req_i.operand_b});

    // --------------------
    // Shifter
    // --------------------
    assign shift_left  = (req_i.operator == SLL);
    assign shift_arith = (req_i.operator == SRA);

    // Left shifts go through the right shifter on reversed bits
    for (genvar k = 0; k < XLEN; k++) begin : gen_rev
        assign operand_a_rev[k]  = req_i.operand_a[XLEN-1-k];
        assign shift_left_res[k] = shift_right[XLEN-1-k];
    end

    assign shift_in        = shift_left ? operand_a_rev : req_i.operand_a;
    assign shift_right_ext = $unsigned($signed({shift_arith & shift_in[XLEN-1], shift_in})
                                       >>> req_i.operand_b[4:0]);
    assign shift_right     = shift_right_ext[XLEN-1:0];
    assign shift_res       = shift_left ? shift_left_res : shift_right;

    // Result mux, zero for branch and polar operators
    always_comb begin
        unique case (req_i.operator)
            ADD, SUB:       int_result_o = adder_sum;
            ANDL:           int_result_o = req_i.operand_a & req_i.operand_b;
            ORL:            int_result_o = req_i.operand_a | req_i.operand_b;
            XORL:           int_result_o = req_i.operand_a ^ req_i.operand_b;
            SLL, SRL, SRA:  int_result_o = shift_res;
            SLTS, SLTU:     int_result_o = xlen_t'(less);
            default:        int_result_o = '0;
        endcase
    end

    // Branch resolution
    always_comb begin
        unique case (req_i.operator)
            EQ:       branch_res_o = adder_zero;
            NE:       branch_res_o = ~adder_zero;
            LTS, LTU: branch_res_o = less;
            GES, GEU: branch_res_o = ~less;
            default:  branch_res_o = 1'b1;
        endcase
    end

endmodule

// ==== logic/polar_lane.sv ====
// One signed 8-bit polar lane computing the R, F or G function
`timescale 1ns/1ps

module polar_lane (
    input  alu_pkg::lane_in_t lane_i,
    input  alu_pkg::lane_op_e lane_op_i,
    output alu_pkg::lane_t    lane_o
);
    import alu_pkg::*;

    logic                   sign_diff;
    logic [LANE_W-1:0]      mag_a;
    logic [LANE_W-1:0]      mag_b;
    logic [LANE_W-1:0]      mag_min;
    logic signed [LANE_W:0] sum_add;
    logic signed [LANE_W:0] sum_sub;
    logic signed [LANE_W:0] sum_g;
    lane_t                  func_r;
    lane_t                  func_f;
    lane_t                  func_g;

    // R: hard decision on the sign of a
    assign func_r = (lane_i.a[LANE_W-1] && !lane_i.r_force_zero) ? lane_t'(1) : '0;

    // --------------------
    // F: min-sum
    // --------------------
    assign sign_diff = lane_i.a[LANE_W-1] ^ lane_i.b[LANE_W-1];
    // -128 wraps to 8'h80, read as 128 unsigned
    assign mag_a     = lane_i.a[LANE_W-1] ? -lane_i.a : lane_i.a;
    assign mag_b     = lane_i.b[LANE_W-1] ? -lane_i.b : lane_i.b;
    assign mag_min   = (mag_a > mag_b) ? mag_b : mag_a;
    assign func_f    = sign_diff ? lane_t'(-mag_min) : lane_t'(mag_min);

    // --------------------
    // G: saturating add/sub
    // --------------------
    assign sum_add = lane_i.a + lane_i.b;
    assign sum_sub = lane_i.b - lane_i.a;
    // Zero imm byte selects a+b, anything else b-a
    assign sum_g   = (lane_i.imm_byte == '0) ? sum_add : sum_sub;

    always_comb begin
        if (sum_g > SAT_MAX) begin
            func_g = lane_t'(SAT_MAX);
        end else if (sum_g < -SAT_MAX) begin
            func_g = lane_t'(-SAT_MAX);
        end else begin
            func_g = sum_g[LANE_W-1:0];
        end
    end

    // Output select
    always_comb begin
        unique case (lane_op_i)
            LANE_F:  lane_o = func_f;
            LANE_G:  lane_o = func_g;
            default: lane_o = func_r;
        endcase
    end

endmodule

// ==== logic/polar_lane_split.sv ====
// Polar operator decode and per-lane operand slicing
`timescale 1ns/1ps

module polar_lane_split (
    input  alu_pkg::alu_req_t    req_i,
    output alu_pkg::lane_in_t    lane_in_o [alu_pkg::NUM_LANES],
    output alu_pkg::lane_op_e    lane_op_o,
    output alu_pkg::result_sel_e result_sel_o
);
    import alu_pkg::*;

    logic r_force_zero;

    // R is suppressed for all lanes when the low byte of b is one
    assign r_force_zero = (req_i.operand_b[LANE_W-1:0] == LANE_W'(1));

    // --------------------
    // Lane slicing
    // --------------------
    always_comb begin
        for (int k = 0; k < NUM_LANES; k++) begin
            lane_in_o[k].a            = req_i.operand_a[k*LANE_W +: LANE_W];
            lane_in_o[k].b            = req_i.operand_b[k*LANE_W +: LANE_W];
            lane_in_o[k].imm_byte     = req_i.imm[k*LANE_W +: LANE_W];
            lane_in_o[k].r_force_zero = r_force_zero;
        end
    end

    // --------------------
    // Operator decode
    // --------------------
    always_comb begin
        lane_op_o    = LANE_R;
        result_sel_o = SEL_INT;
        unique case (req_i.operator)
            PL_R: begin
                lane_op_o    = LANE_R;
                result_sel_o = SEL_LANES;
            end
            PL_F: begin
                lane_op_o    = LANE_F;
                result_sel_o = SEL_LANES;
            end
            PL_G: begin
                lane_op_o    = LANE_G;
                result_sel_o = SEL_LANES;
            end
            PL_VADDREP: result_sel_o = SEL_VADDREP;
            PL_SPCXOR:  result_sel_o = SEL_SPCXOR;
            // Integer and branch operators
            default: ;
        endcase
    end

endmodule

// ==== logic/alu_pkg.sv ====
// ALU widths, operator encoding, lane and selection enums, request and lane structs
package alu_pkg;

    // --------------------
    // Widths
    // --------------------
    localparam int XLEN      = 32;
    localparam int LANE_W    = 8;
    localparam int NUM_LANES = XLEN / LANE_W;
    // Polar lanes clamp symmetrically to +/- this bound
    localparam int SAT_MAX   = 127;

    typedef logic [XLEN-1:0]          xlen_t;
    typedef logic signed [LANE_W-1:0] lane_t;

    // --------------------
    // Operator encoding
    // --------------------
    typedef enum logic [4:0] {
        ADD        = 5'd0,
        SUB        = 5'd1,
        ANDL       = 5'd2,
        ORL        = 5'd3,
        XORL       = 5'd4,
        SLL        = 5'd5,
        SRL        = 5'd6,
        SRA        = 5'd7,
        SLTS       = 5'd8,
        SLTU       = 5'd9,
        EQ         = 5'd10,
        NE         = 5'd11,
        LTS        = 5'd12,
        LTU        = 5'd13,
        GES        = 5'd14,
        GEU        = 5'd15,
        PL_R       = 5'd16,
        PL_F       = 5'd17,
        PL_G       = 5'd18,
        PL_VADDREP = 5'd19,
        PL_SPCXOR  = 5'd20
    } alu_op_e;

    // Function every polar lane produces
    typedef enum logic [1:0] {
        LANE_R,
        LANE_F,
        LANE_G
    } lane_op_e;

    // Source of the registered result
    typedef enum logic [1:0] {
        SEL_INT,
        SEL_LANES,
        SEL_VADDREP,
        SEL_SPCXOR
    } result_sel_e;

    // --------------------
    // Structs
    // --------------------
    typedef struct packed {
        alu_op_e operator;
        xlen_t   operand_a;
        xlen_t   operand_b;
        xlen_t   imm;
    } alu_req_t;

    typedef struct packed {
        lane_t a;
        lane_t b;
        lane_t imm_byte;
        logic  r_force_zero;
    } lane_in_t;

endpackage
